//--- logic/pkt_sram.sv
`timescale 1ns/1ps

module pkt_sram #(
   parameter int ADDR_W = 10
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  wr_cmd_i,
   input  logic [ADDR_W-1:0]     wr_addr_i,
   input  qdr_replay_pkg::beat_t wr_data_i,
   input  logic                  rd_cmd_i,
   input  logic [ADDR_W-1:0]     rd_addr_i,
   output logic                  rd_valid_o,
   output qdr_replay_pkg::beat_t rd_data_o
);
   import qdr_replay_pkg::*;

   localparam int WORDS = 1 << ADDR_W;

   beat_t                 mem [WORDS];
   beat_t                 data_pipe [RD_LATENCY];
   logic [RD_LATENCY-1:0] vld_pipe;

   always_ff @(posedge clk_i) begin
      if (wr_cmd_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // Registered array read, then further stages up to the read latency
   always_ff @(posedge clk_i) begin
      if (rd_cmd_i) begin
         data_pipe[0] <= mem[rd_addr_i];
      end
      for (int i = 1; i < RD_LATENCY; i++) begin
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         vld_pipe <= '0;
      end else begin
         vld_pipe <= {vld_pipe[RD_LATENCY-2:0], rd_cmd_i};
      end
   end

   assign rd_valid_o = vld_pipe[RD_LATENCY-1];
   assign rd_data_o  = data_pipe[RD_LATENCY-1];

endmodule

//--- logic/qdr_replay_pkg.sv
package qdr_replay_pkg;

   // Stream data width and its byte-enable width
   localparam int DATA_W = 64;
   localparam int KEEP_W = DATA_W / 8;

   // Memory read latency in cycles, from read command to returned word
   localparam int RD_LATENCY = 2;

   // Width of the replay pass count
   localparam int COUNT_W = 16;

   // One stream beat, stored as one memory word
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] keep;
      logic              last;
   } beat_t;

   // Controller states
   // Capture is open, beats are written in arrival order
   // Stored holds a closed capture and waits for a replay request
   // Replay reads the stored beats back once per pass
   typedef enum logic [1:0] {
      ST_CAPTURE,
      ST_STORED,
      ST_REPLAY
   } ctrl_state_e;

endpackage

//--- logic/qdr_replay_top.sv
`timescale 1ns/1ps

module qdr_replay_top #(
   parameter int ADDR_W          = 10,
   parameter int FIFO_DEPTH_BITS = 4
) (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  qdr_replay_pkg::beat_t              s_beat_i,
   input  logic                               s_valid_i,
   output logic                               s_ready_o,
   output qdr_replay_pkg::beat_t              m_beat_o,
   output logic                               m_valid_o,
   input  logic                               m_ready_i,
   input  logic                               sw_rst_i,
   input  logic                               wr_done_i,
   input  logic                               start_replay_i,
   input  logic [qdr_replay_pkg::COUNT_W-1:0] replay_count_i,
   output logic                               replay_busy_o
);
   import qdr_replay_pkg::*;

   logic              wr_cmd;
   logic [ADDR_W-1:0] wr_addr;
   beat_t             wr_data;
   logic              rd_cmd;
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_valid;
   beat_t             rd_data;
   logic              fifo_nearly_full;
   logic              fifo_empty;

   replay_ctrl #(
      .ADDR_W (ADDR_W)
   ) u_ctrl (
      .clk_i              (clk_i),
      .rst_n_i            (rst_n_i),
      .s_valid_i          (s_valid_i),
      .s_ready_o          (s_ready_o),
      .s_beat_i           (s_beat_i),
      .sw_rst_i           (sw_rst_i),
      .wr_done_i          (wr_done_i),
      .start_replay_i     (start_replay_i),
      .replay_count_i     (replay_count_i),
      .wr_cmd_o           (wr_cmd),
      .wr_addr_o          (wr_addr),
      .wr_data_o          (wr_data),
      .rd_cmd_o           (rd_cmd),
      .rd_addr_o          (rd_addr),
      .fifo_nearly_full_i (fifo_nearly_full),
      .fifo_empty_i       (fifo_empty),
      .replay_busy_o      (replay_busy_o)
   );

   pkt_sram #(
      .ADDR_W (ADDR_W)
   ) u_sram (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_cmd_i   (wr_cmd),
      .wr_addr_i  (wr_addr),
      .wr_data_i  (wr_data),
      .rd_cmd_i   (rd_cmd),
      .rd_addr_i  (rd_addr),
      .rd_valid_o (rd_valid),
      .rd_data_o  (rd_data)
   );

   // Read returns land in the store FIFO, which feeds the output stream
   replay_fifo #(
      .FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
   ) u_fifo (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .wr_en_i       (rd_valid),
      .din_i         (rd_data),
      .rd_en_i       (m_ready_i),
      .dout_o        (m_beat_o),
      .empty_o       (fifo_empty),
      .nearly_full_o (fifo_nearly_full)
   );

   assign m_valid_o = ~fifo_empty;

endmodule

//--- logic/replay_ctrl.sv
`timescale 1ns/1ps

module replay_ctrl #(
   parameter int ADDR_W = 10
) (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic                               s_valid_i,
   output logic                               s_ready_o,
   input  qdr_replay_pkg::beat_t              s_beat_i,
   input  logic                               sw_rst_i,
   input  logic                               wr_done_i,
   input  logic                               start_replay_i,
   input  logic [qdr_replay_pkg::COUNT_W-1:0] replay_count_i,
   output logic                               wr_cmd_o,
   output logic [ADDR_W-1:0]                  wr_addr_o,
   output qdr_replay_pkg::beat_t              wr_data_o,
   output logic                               rd_cmd_o,
   output logic [ADDR_W-1:0]                  rd_addr_o,
   input  logic                               fifo_nearly_full_i,
   input  logic                               fifo_empty_i,
   output logic                               replay_busy_o
);
   import qdr_replay_pkg::*;

   localparam int IF_W = $clog2(RD_LATENCY + 1);

   ctrl_state_e           state;
   logic [ADDR_W-1:0]     wr_addr;
   logic [ADDR_W-1:0]     rd_addr;
   logic [COUNT_W-1:0]    passes_left;
   logic [RD_LATENCY-1:0] rd_sr;
   logic [IF_W-1:0]       inflight;
   logic                  busy_q;
   logic                  mem_full;
   logic                  rd_last;
   logic                  start_ok;

   // Top address is never written, so wr_addr always fits the stored length
   assign mem_full = (wr_addr == {ADDR_W{1'b1}});
   assign rd_last  = (rd_addr == wr_addr - ADDR_W'(1));
   assign start_ok = (state == ST_STORED) && start_replay_i &&
                     (replay_count_i != '0) && (wr_addr != '0);

   assign s_ready_o = (state == ST_CAPTURE) && !mem_full && !sw_rst_i;
   assign wr_cmd_o  = s_valid_i & s_ready_o;
   assign wr_addr_o = wr_addr;
   assign wr_data_o = s_beat_i;

   // Reads only go out while the store FIFO has credit for them
   assign rd_cmd_o  = (state == ST_REPLAY) && !fifo_nearly_full_i;
   assign rd_addr_o = rd_addr;

   assign replay_busy_o = busy_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state       <= ST_CAPTURE;
         wr_addr     <= '0;
         rd_addr     <= '0;
         passes_left <= '0;
      end else if (sw_rst_i) begin
         state       <= ST_CAPTURE;
         wr_addr     <= '0;
         rd_addr     <= '0;
         passes_left <= '0;
      end else begin
         case (state)
            ST_CAPTURE: begin
               if (wr_cmd_o) begin
                  wr_addr <= wr_addr + 1'b1;
               end
               if (wr_done_i) begin
                  state <= ST_STORED;
               end
            end
            ST_STORED: begin
               if (start_ok) begin
                  state       <= ST_REPLAY;
                  rd_addr     <= '0;
                  passes_left <= replay_count_i;
               end
            end
            ST_REPLAY: begin
               if (rd_cmd_o) begin
                  if (rd_last) begin
                     rd_addr     <= '0;
                     passes_left <= passes_left - 1'b1;
                     if (passes_left == COUNT_W'(1)) begin
                        state <= ST_STORED;
                     end
                  end else begin
                     rd_addr <= rd_addr + 1'b1;
                  end
               end
            end
            default: state <= ST_CAPTURE;
         endcase
      end
   end

   // Reads between command and return, tracked to know when replay has drained
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_sr    <= '0;
         inflight <= '0;
      end else begin
         rd_sr    <= {rd_sr[RD_LATENCY-2:0], rd_cmd_o};
         inflight <= inflight + IF_W'(rd_cmd_o) - IF_W'(rd_sr[RD_LATENCY-1]);
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
      end else if (start_ok && !sw_rst_i) begin
         busy_q <= 1'b1;
      end else if (state != ST_REPLAY && inflight == '0 && fifo_empty_i) begin
         busy_q <= 1'b0;
      end
   end

endmodule

//--- logic/replay_fifo.sv
`timescale 1ns/1ps

module replay_fifo #(
   parameter int FIFO_DEPTH_BITS = 4
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  wr_en_i,
   input  qdr_replay_pkg::beat_t din_i,
   input  logic                  rd_en_i,
   output qdr_replay_pkg::beat_t dout_o,
   output logic                  empty_o,
   output logic                  nearly_full_o
);
   import qdr_replay_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_BITS;
   // Threshold leaves room for every read that may still be in flight
   localparam int NF_LEVEL = DEPTH - (RD_LATENCY + 1);

   beat_t                      mem [DEPTH];
   logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
   logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
   logic [FIFO_DEPTH_BITS:0]   count;
   logic                       rd_ok;

   assign rd_ok = rd_en_i & ~empty_o;

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en_i, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head word shows through while not empty
   assign dout_o        = mem[rd_ptr];
   assign empty_o       = (count == '0);
   assign nearly_full_o = (count > (FIFO_DEPTH_BITS+1)'(NF_LEVEL));

endmodule

//--- project.f
logic/qdr_replay_pkg.sv
logic/pkt_sram.sv
logic/replay_fifo.sv
logic/replay_ctrl.sv
logic/qdr_replay_top.sv
tb/tb_qdr_replay.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module tb_qdr_replay \
   -Mdir obj_dir -o sim_qdr_replay \
   && ./obj_dir/sim_qdr_replay | tee /dev/stderr | grep -qx "Simulation passed" \
   && echo "run.sh: PASS" \
   || { echo "run.sh: FAIL"; exit 1; }

//--- tb/tb_qdr_replay.sv
`timescale 1ns/1ps

module tb_qdr_replay;
   import qdr_replay_pkg::*;

   localparam int PKTS            = 3;
   localparam int MAX_PKT_LEN     = 6;
   localparam int MAX_CAP         = PKTS * MAX_PKT_LEN;
   localparam int EXTRA_BEATS     = 4;
   localparam int SHORT_LEN       = 2;
   localparam int QUIET_CYCLES    = 20;
   // One capture in, then 1 + 3 + 2 + 1 passes out, plus two short captures and one replay
   localparam int TOTAL_BEATS     = MAX_CAP * 8 + EXTRA_BEATS + 3 * SHORT_LEN;
   localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 2000;
   localparam int WAIT_LIMIT      = 1000;

   logic               clk_i = 1'b0;
   logic               rst_n_i;
   beat_t              s_beat_i;
   logic               s_valid_i;
   logic               s_ready_o;
   beat_t              m_beat_o;
   logic               m_valid_o;
   logic               m_ready_i;
   logic               sw_rst_i;
   logic               wr_done_i;
   logic               start_replay_i;
   logic [COUNT_W-1:0] replay_count_i;
   logic               replay_busy_o;

   beat_t cap_q [$];
   beat_t exp_mem [1024];
   int    exp_wr = 0;
   int    exp_rd = 0;
   int    err_cnt = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   int    seed = 74;
   int    ready_seed;
   logic  rand_ready;
   logic  ready_rand_now;
   logic  capture_closed;
   logic  quiet;

   qdr_replay_top dut (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .s_beat_i       (s_beat_i),
      .s_valid_i      (s_valid_i),
      .s_ready_o      (s_ready_o),
      .m_beat_o       (m_beat_o),
      .m_valid_o      (m_valid_o),
      .m_ready_i      (m_ready_i),
      .sw_rst_i       (sw_rst_i),
      .wr_done_i      (wr_done_i),
      .start_replay_i (start_replay_i),
      .replay_count_i (replay_count_i),
      .replay_busy_o  (replay_busy_o)
   );

   always #2 clk_i = ~clk_i;

   // Output back-pressure, ready about three cycles in four
   always @(posedge clk_i) begin
      ready_rand_now = rand_ready;
      #0.5;
      if (ready_rand_now) begin
         m_ready_i = ($random(ready_seed) % 4) != 0;
      end else begin
         m_ready_i = 1'b1;
      end
   end

   // Expected index advances on every output transfer
   always @(posedge clk_i) begin
      if (rst_n_i && m_valid_o && m_ready_i) begin
         exp_rd <= exp_rd + 1;
      end
   end

   a_beat_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (m_valid_o && m_ready_i && exp_rd < exp_wr) |-> (m_beat_o == exp_mem[exp_rd]))
      else begin
         err_cnt++;
         $display("error at %0t: m_beat_o expected %h, got %h", $time,
                  exp_mem[$sampled(exp_rd)], $sampled(m_beat_o));
      end

   a_no_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (m_valid_o && m_ready_i) |-> (exp_rd < exp_wr))
      else begin
         err_cnt++;
         $display("at %0t an unexpected beat left the output stream", $time);
      end

   a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_beat_o)))
      else begin
         err_cnt++;
         $display("at %0t the output stream changed while m_ready_i was low", $time);
      end

   a_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_valid_o |-> replay_busy_o)
      else begin
         err_cnt++;
         $display("error at %0t: replay_busy_o expected 1, got 0", $time);
      end

   a_closed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      capture_closed |-> !s_ready_o)
      else begin
         err_cnt++;
         $display("error at %0t: s_ready_o expected 0, got 1", $time);
      end

   a_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      quiet |-> (!m_valid_o && !replay_busy_o))
      else begin
         err_cnt++;
         $display("at %0t an ignored start produced activity, m_valid_o %b replay_busy_o %b",
                  $time, $sampled(m_valid_o), $sampled(replay_busy_o));
      end

   task automatic step_clock();
      @(posedge clk_i);
      #0.5;
   endtask

   task automatic make_beat(output beat_t b, input logic last);
      b.data = {$random(seed), $random(seed)};
      b.keep = last ? KEEP_W'($random(seed)) | KEEP_W'(1) : '1;
      b.last = last;
   endtask

   // Holds one beat until the DUT takes it, with random idle cycles before
   task automatic send_beat(input beat_t b);
      logic taken;
      taken = 1'b0;
      while (($random(seed) & 3) == 0) begin
         step_clock();
      end
      s_beat_i  = b;
      s_valid_i = 1'b1;
      while (!taken) begin
         #1;
         taken = s_ready_o;
         if (taken) begin
            cap_q.push_back(b);
         end
         step_clock();
      end
      s_valid_i = 1'b0;
   endtask

   task automatic send_packet(input int len);
      beat_t b;
      for (int i = 0; i < len; i++) begin
         make_beat(b, i == len - 1);
         send_beat(b);
      end
   endtask

   task automatic close_capture();
      wr_done_i = 1'b1;
      step_clock();
      wr_done_i      = 1'b0;
      capture_closed = 1'b1;
   endtask

   task automatic pulse_sw_rst();
      sw_rst_i       = 1'b1;
      capture_closed = 1'b0;
      step_clock();
      sw_rst_i = 1'b0;
   endtask

   task automatic queue_expected(input int passes);
      for (int p = 0; p < passes; p++) begin
         foreach (cap_q[i]) begin
            exp_mem[exp_wr] = cap_q[i];
            exp_wr++;
         end
      end
   endtask

   task automatic pulse_start(input int count);
      replay_count_i = COUNT_W'(count);
      start_replay_i = 1'b1;
      step_clock();
      start_replay_i = 1'b0;
   endtask

   task automatic wait_replay_done();
      int n;
      n = 0;
      while (replay_busy_o && n < WAIT_LIMIT) begin
         step_clock();
         n++;
      end
      if (replay_busy_o) begin
         err_cnt++;
         $display("at %0t the replay did not finish within %0d cycles", $time, WAIT_LIMIT);
      end
      assert (exp_rd == exp_wr) else begin
         err_cnt++;
         $display("error at %0t: beats delivered expected %0d, got %0d", $time, exp_wr, exp_rd);
      end
   endtask

   task automatic replay_and_wait(input int count);
      queue_expected(count);
      pulse_start(count);
      wait_replay_done();
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (err_cnt == errs_before) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
      end
   endtask

   initial begin
      int errs;
      rst_n_i        = 1'b0;
      s_beat_i       = '0;
      s_valid_i      = 1'b0;
      m_ready_i      = 1'b1;
      sw_rst_i       = 1'b0;
      wr_done_i      = 1'b0;
      start_replay_i = 1'b0;
      replay_count_i = '0;
      rand_ready     = 1'b0;
      capture_closed = 1'b0;
      quiet          = 1'b0;
      ready_seed     = seed + 1;
      repeat (4) @(posedge clk_i);
      #0.5;
      rst_n_i = 1'b1;
      step_clock();

      errs = err_cnt;
      for (int p = 0; p < PKTS; p++) begin
         send_packet(1 + $unsigned($random(seed)) % MAX_PKT_LEN);
      end
      close_capture();
      replay_and_wait(1);
      report_test("single replay", errs);

      errs = err_cnt;
      replay_and_wait(3);
      report_test("three passes", errs);

      errs = err_cnt;
      rand_ready = 1'b1;
      replay_and_wait(2);
      rand_ready = 1'b0;
      report_test("random back-pressure", errs);

      // Beats offered after capture closed must never be stored
      errs = err_cnt;
      for (int i = 0; i < EXTRA_BEATS; i++) begin
         make_beat(s_beat_i, 1'b1);
         s_valid_i = 1'b1;
         step_clock();
      end
      s_valid_i = 1'b0;
      replay_and_wait(1);
      report_test("input closed after done", errs);

      errs = err_cnt;
      pulse_sw_rst();
      cap_q.delete();
      send_packet(SHORT_LEN);
      close_capture();
      rand_ready = 1'b1;
      replay_and_wait(1);
      rand_ready = 1'b0;
      report_test("software reset", errs);

      errs = err_cnt;
      quiet = 1'b1;
      pulse_start(0);
      repeat (QUIET_CYCLES) step_clock();
      pulse_sw_rst();
      // Capture still open but already holding beats
      send_packet(SHORT_LEN);
      pulse_start(1);
      repeat (QUIET_CYCLES) step_clock();
      quiet = 1'b0;
      report_test("ignored starts", errs);

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("watchdog expired after %0d cycles, the run was stopped", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule
